/* Makefile */
# Verilator build and run of the snake frame testbench.

VERILATOR ?= verilator
TOP       ?= tb_snake_frame
FILELIST  ?= snake_frame_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/snake_consts.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "sim passed" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/apple_spot.sv */
`include "snake_consts.svh"

module apple_spot (
    input  logic                clk,
    input  logic                nrst,
    input  logic                apple_load,
    input  logic                apple_clear,
    input  logic [`COORD_W-1:0] apple_x,
    input  logic [`COORD_W-1:0] apple_y,
    cell_probe_if.source        probe
);

    logic [`COORD_W-1:0] pos_x;
    logic [`COORD_W-1:0] pos_y;
    logic                valid;
    logic                match;

    // ----------------------------------------------------------------------
    // Apple state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid <= 1'b0;
        end else if (apple_clear) begin
            valid <= 1'b0;          // Clear beats load.
        end else if (apple_load) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (apple_load) begin
            pos_x <= apple_x;
            pos_y <= apple_y;
        end
    end

    // ----------------------------------------------------------------------
    // Occupancy answer
    // ----------------------------------------------------------------------
    assign match = (pos_x == probe.x) && (pos_y == probe.y);

    always_comb begin
        probe.occupied = probe.active && valid && match;
        probe.kind     = probe.occupied ? snake_pkg::apple_c : snake_pkg::blank;
    end

    // Loader outside must never place the apple on the border.
    a_apple_inside: assert property (
        @(posedge clk) disable iff (!nrst)
        valid |-> (pos_x != 0) && (pos_x != `COORD_W'(`GRID_W - 1)) &&
                  (pos_y != 0) && (pos_y != `COORD_W'(`GRID_H - 1))
    );

endmodule

/* hdl/cell_probe_if.sv */
`include "snake_consts.svh"

interface cell_probe_if;

    logic [`COORD_W-1:0] x;         // Cell column under the scan.
    logic [`COORD_W-1:0] y;         // Cell row under the scan.
    logic active;                   // Scan is running this cycle.
    logic occupied;                 // Source claims the cell.
    snake_pkg::obj_code_t kind;     // What the source puts there.

    // Scan side asks about one cell per cycle.
    modport tracker (
        output x, y, active,
        input  occupied, kind
    );

    // Object side answers from its current state, same cycle.
    modport source (
        input  x, y, active,
        output occupied, kind
    );

endinterface

/* hdl/frame_tracker.sv */
`include "snake_consts.svh"

module frame_tracker (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  enable,
    cell_probe_if.tracker         snake_probe,
    cell_probe_if.tracker         apple_probe,
    input  logic [`COORD_W-1:0]   rd_x,
    input  logic [`COORD_W-1:0]   rd_y,
    output snake_pkg::obj_code_t  rd_code,
    output logic [`COORD_W-1:0]   x,
    output logic [`COORD_W-1:0]   y,
    output logic                  diff,
    output logic                  frame_done
);

    localparam int CELLS  = `GRID_W * `GRID_H;
    localparam int ADDR_W = $clog2(CELLS);
    localparam logic [`COORD_W-1:0] X_LAST = `COORD_W'(`GRID_W - 1);
    localparam logic [`COORD_W-1:0] Y_LAST = `COORD_W'(`GRID_H - 1);

    snake_pkg::obj_code_t mem [CELLS];
    snake_pkg::obj_code_t code;
    logic [`COORD_W-1:0]  x_q;
    logic [`COORD_W-1:0]  y_q;
    logic [ADDR_W-1:0]    addr;
    logic [ADDR_W-1:0]    rd_addr;
    logic                 on_border;

    // ----------------------------------------------------------------------
    // Raster scan, x fastest
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (enable) begin
            if (x_q == X_LAST) begin
                x_q <= '0;
                y_q <= (y_q == Y_LAST) ? '0 : y_q + 1'b1;
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    assign snake_probe.x      = x_q;
    assign snake_probe.y      = y_q;
    assign snake_probe.active = enable;
    assign apple_probe.x      = x_q;
    assign apple_probe.y      = y_q;
    assign apple_probe.active = enable;

    // ----------------------------------------------------------------------
    // Priority merge
    // ----------------------------------------------------------------------
    assign on_border = (x_q == 0) || (x_q == X_LAST) || (y_q == 0) || (y_q == Y_LAST);

    always_comb begin
        if (on_border) begin
            code = snake_pkg::border_c;
        end else if (snake_probe.occupied) begin
            code = snake_probe.kind;       // Head or body, decided by the snake.
        end else if (apple_probe.occupied) begin
            code = apple_probe.kind;
        end else begin
            code = snake_pkg::blank;
        end
    end

    // ----------------------------------------------------------------------
    // Frame memory
    // ----------------------------------------------------------------------
    assign addr    = ADDR_W'(y_q) * ADDR_W'(`GRID_W) + ADDR_W'(x_q);
    assign rd_addr = ADDR_W'(rd_y) * ADDR_W'(`GRID_W) + ADDR_W'(rd_x);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < CELLS; i++) begin
                mem[i] <= snake_pkg::blank;
            end
        end else if (enable) begin
            mem[addr] <= code;
        end
    end

    // Rows past the grid read as blank.
    assign rd_code = (rd_y < `COORD_W'(`GRID_H)) ? mem[rd_addr] : snake_pkg::blank;

    assign diff       = enable && (code != mem[addr]);
    assign frame_done = enable && (x_q == X_LAST) && (y_q == Y_LAST);
    assign x          = x_q;
    assign y          = y_q;

    // Scan parks on its cell while idle.
    a_idle_hold: assert property (
        @(posedge clk) disable iff (!nrst)
        !enable |=> $stable(x_q) && $stable(y_q)
    );

    a_scan_grid: assert property (
        @(posedge clk) disable iff (!nrst) y_q < `COORD_W'(`GRID_H)
    );

endmodule

/* hdl/snake_body.sv */
`include "snake_consts.svh"

module snake_body (
    input  logic              clk,
    input  logic              nrst,
    input  logic              step,
    input  logic              grow,
    input  snake_pkg::dir_t   dir,
    cell_probe_if.source      probe
);

    localparam int MAX_LEN = `SNAKE_MAX_LEN;
    localparam int LEN_W   = $clog2(MAX_LEN + 1);
    localparam logic [`COORD_W-1:0] X_MAX = `COORD_W'(`GRID_W - 2);
    localparam logic [`COORD_W-1:0] Y_MAX = `COORD_W'(`GRID_H - 2);

    logic [`COORD_W-1:0] seg_x [MAX_LEN];   // Index 0 is the head.
    logic [`COORD_W-1:0] seg_y [MAX_LEN];
    logic [LEN_W-1:0]    len;
    logic [`COORD_W-1:0] next_x;
    logic [`COORD_W-1:0] next_y;
    logic [MAX_LEN-1:0]  hit;

    // ----------------------------------------------------------------------
    // Head movement with wrap inside the border
    // ----------------------------------------------------------------------
    always_comb begin
        next_x = seg_x[0];
        next_y = seg_y[0];
        case (dir)
            snake_pkg::dir_up:    next_y = (seg_y[0] == 1) ? Y_MAX : seg_y[0] - 1'b1;
            snake_pkg::dir_down:  next_y = (seg_y[0] == Y_MAX) ? `COORD_W'(1) : seg_y[0] + 1'b1;
            snake_pkg::dir_left:  next_x = (seg_x[0] == 1) ? X_MAX : seg_x[0] - 1'b1;
            snake_pkg::dir_right: next_x = (seg_x[0] == X_MAX) ? `COORD_W'(1) : seg_x[0] + 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                // First three segments trail to the left of the start cell.
                seg_x[i] <= (i < 3) ? `COORD_W'(`START_X - i) : `COORD_W'(`START_X);
                seg_y[i] <= `COORD_W'(`START_Y);
            end
            len <= LEN_W'(3);
        end else if (step) begin
            seg_x[0] <= next_x;
            seg_y[0] <= next_y;
            for (int i = 1; i < MAX_LEN; i++) begin
                seg_x[i] <= seg_x[i-1];   // Follow the predecessor.
                seg_y[i] <= seg_y[i-1];
            end
            if (grow && (len < LEN_W'(MAX_LEN))) begin
                len <= len + 1'b1;        // Old tail becomes live.
            end
        end
    end

    // ----------------------------------------------------------------------
    // Occupancy answer for the probed cell
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < MAX_LEN; i++) begin
            hit[i] = (LEN_W'(i) < len) && (seg_x[i] == probe.x) && (seg_y[i] == probe.y);
        end
    end

    always_comb begin
        probe.occupied = probe.active && (|hit);
        if (!probe.occupied) begin
            probe.kind = snake_pkg::blank;
        end else if (hit[0]) begin
            probe.kind = snake_pkg::snake_head;   // Head wins over overlap.
        end else begin
            probe.kind = snake_pkg::snake_body;
        end
    end

    a_len_max: assert property (
        @(posedge clk) disable iff (!nrst) len <= LEN_W'(MAX_LEN)
    );

    // Wrap logic must keep the head off every edge cell.
    a_head_inside: assert property (
        @(posedge clk) disable iff (!nrst)
        (seg_x[0] != 0) && (seg_x[0] != `COORD_W'(`GRID_W - 1)) &&
        (seg_y[0] != 0) && (seg_y[0] != `COORD_W'(`GRID_H - 1))
    );

endmodule

/* hdl/snake_consts.svh */
`ifndef SNAKE_CONSTS_SVH
`define SNAKE_CONSTS_SVH

// ----------------------------------------------------------------------
// Playfield geometry
// ----------------------------------------------------------------------
`define GRID_W 16           // Cells per row.
`define GRID_H 12           // Rows per frame.
`define COORD_W 4           // Bits per cell coordinate.

// ----------------------------------------------------------------------
// Snake limits
// ----------------------------------------------------------------------
`define SNAKE_MAX_LEN 16    // Segment registers available.
`define START_X 7           // Head column after reset.
`define START_Y 5           // Head row after reset.

`endif

/* hdl/snake_frame_top.sv */
`include "snake_consts.svh"

module snake_frame_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  enable,
    input  logic                  step,
    input  logic                  grow,
    input  snake_pkg::dir_t       dir,
    input  logic                  apple_load,
    input  logic                  apple_clear,
    input  logic [`COORD_W-1:0]   apple_x,
    input  logic [`COORD_W-1:0]   apple_y,
    input  logic [`COORD_W-1:0]   rd_x,
    input  logic [`COORD_W-1:0]   rd_y,
    output snake_pkg::obj_code_t  rd_code,
    output logic [`COORD_W-1:0]   x,
    output logic [`COORD_W-1:0]   y,
    output logic                  diff,
    output logic                  frame_done
);

    cell_probe_if snake_probe ();
    cell_probe_if apple_probe ();

    snake_body u_snake_body (
        .clk   (clk),
        .nrst  (nrst),
        .step  (step),
        .grow  (grow),
        .dir   (dir),
        .probe (snake_probe.source)
    );

    apple_spot u_apple_spot (
        .clk         (clk),
        .nrst        (nrst),
        .apple_load  (apple_load),
        .apple_clear (apple_clear),
        .apple_x     (apple_x),
        .apple_y     (apple_y),
        .probe       (apple_probe.source)
    );

    // Scan and frame store.
    frame_tracker u_frame_tracker (
        .clk         (clk),
        .nrst        (nrst),
        .enable      (enable),
        .snake_probe (snake_probe.tracker),
        .apple_probe (apple_probe.tracker),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .rd_code     (rd_code),
        .x           (x),
        .y           (y),
        .diff        (diff),
        .frame_done  (frame_done)
    );

endmodule

/* hdl/snake_pkg.sv */
package snake_pkg;

    // Object code held per cell in the frame memory.
    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    // Heading of the snake head.
    typedef enum logic [1:0] {
        dir_up    = 2'd0,   // Row decreases.
        dir_down  = 2'd1,   // Row increases.
        dir_left  = 2'd2,   // Column decreases.
        dir_right = 2'd3    // Column increases.
    } dir_t;

endpackage

/* snake_frame_top.f */
+incdir+hdl
hdl/snake_pkg.sv
hdl/cell_probe_if.sv
hdl/snake_body.sv
hdl/apple_spot.sv
hdl/frame_tracker.sv
hdl/snake_frame_top.sv
tests/tb_snake_frame.sv

/* tests/tb_snake_frame.sv */
`include "snake_consts.svh"

module tb_snake_frame;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CELLS       = `GRID_W * `GRID_H;
    localparam int MAX_LEN     = `SNAKE_MAX_LEN;
    localparam int SWEEPS      = 52;                // Readbacks over all tests.
    localparam int WATCHDOG_NS = SWEEPS * 3 * CELLS * 4 + 2000;

    logic                 clk;
    logic                 nrst;
    logic                 enable;
    logic                 step;
    logic                 grow;
    snake_pkg::dir_t      dir;
    logic                 apple_load;
    logic                 apple_clear;
    logic [`COORD_W-1:0]  apple_x;
    logic [`COORD_W-1:0]  apple_y;
    logic [`COORD_W-1:0]  rd_x;
    logic [`COORD_W-1:0]  rd_y;
    snake_pkg::obj_code_t rd_code;
    logic [`COORD_W-1:0]  x;
    logic [`COORD_W-1:0]  y;
    logic                 diff;
    logic                 frame_done;

    int   m_x [MAX_LEN];        // Model segments, index 0 is the head.
    int   m_y [MAX_LEN];
    int   m_len;
    int   a_x;
    int   a_y;
    logic a_valid;

    logic [31:0] lfsr = 32'hcce7b50b;
    int          err_cnt = 0;
    int          diff_total = 0;
    int          en_cnt = 0;
    int          gap = 0;
    int          sweep_diffs = 0;
    int          snake_cells = 0;
    logic        fresh_frame = 1'b1;
    string       test_name = "none";
    event        sweep_end;
    event        check_done;

    snake_frame_top dut0 (
        .clk         (clk),
        .nrst        (nrst),
        .enable      (enable),
        .step        (step),
        .grow        (grow),
        .dir         (dir),
        .apple_load  (apple_load),
        .apple_clear (apple_clear),
        .apple_x     (apple_x),
        .apple_y     (apple_y),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .rd_code     (rd_code),
        .x           (x),
        .y           (y),
        .diff        (diff),
        .frame_done  (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $fatal(1);
    end

    // ----------------------------------------------------------------------
    // Helpers and reference model
    // ----------------------------------------------------------------------
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Fibonacci form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < MAX_LEN; i++) begin
            m_x[i] = (i < 3) ? `START_X - i : `START_X;
            m_y[i] = `START_Y;
        end
        m_len   = 3;
        a_valid = 1'b0;
    endfunction

    function automatic void model_step(input snake_pkg::dir_t d, input logic g);
        int hx;
        int hy;
        hx = m_x[0];
        hy = m_y[0];
        case (d)
            snake_pkg::dir_up:    hy = (hy == 1) ? `GRID_H - 2 : hy - 1;
            snake_pkg::dir_down:  hy = (hy == `GRID_H - 2) ? 1 : hy + 1;
            snake_pkg::dir_left:  hx = (hx == 1) ? `GRID_W - 2 : hx - 1;
            default:              hx = (hx == `GRID_W - 2) ? 1 : hx + 1;
        endcase
        for (int i = MAX_LEN - 1; i > 0; i--) begin
            m_x[i] = m_x[i-1];
            m_y[i] = m_y[i-1];
        end
        m_x[0] = hx;
        m_y[0] = hy;
        if (g && (m_len < MAX_LEN)) m_len++;
    endfunction

    // Border, then head, body, apple, blank.
    function automatic snake_pkg::obj_code_t expected_code(input int cx, input int cy);
        if ((cx == 0) || (cx == `GRID_W - 1) || (cy == 0) || (cy == `GRID_H - 1)) begin
            return snake_pkg::border_c;
        end
        if ((m_x[0] == cx) && (m_y[0] == cy)) return snake_pkg::snake_head;
        for (int i = 1; i < m_len; i++) begin
            if ((m_x[i] == cx) && (m_y[i] == cy)) return snake_pkg::snake_body;
        end
        if (a_valid && (a_x == cx) && (a_y == cy)) return snake_pkg::apple_c;
        return snake_pkg::blank;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------
    task automatic reset_dut();
        @(posedge clk);
        #1 nrst = 1'b0;
        repeat (10) @(posedge clk);
        #1 nrst = 1'b1;
        model_reset();
        fresh_frame = 1'b1;                 // Memory is blank again.
    endtask

    task automatic apply_step(input snake_pkg::dir_t d, input logic g);
        @(posedge clk);
        #1;
        step = 1'b1;
        grow = g;
        dir  = d;
        @(posedge clk);
        #1;
        step = 1'b0;
        grow = 1'b0;
        model_step(d, g);
    endtask

    task automatic load_apple(input int ax, input int ay);
        @(posedge clk);
        #1;
        apple_load = 1'b1;
        apple_x    = `COORD_W'(ax);
        apple_y    = `COORD_W'(ay);
        @(posedge clk);
        #1 apple_load = 1'b0;
        a_x     = ax;
        a_y     = ay;
        a_valid = 1'b1;
    endtask

    task automatic clear_apple();
        @(posedge clk);
        #1 apple_clear = 1'b1;
        @(posedge clk);
        #1 apple_clear = 1'b0;
        a_valid = 1'b0;
    endtask

    // One enabled sweep, then hand the frame to the compare process.
    task automatic run_sweep(input string name);
        test_name = name;
        @(posedge clk);
        #1 enable = 1'b1;
        @(negedge clk);
        while (frame_done !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1 enable = 1'b0;
        check({name, " frame period"}, CELLS, gap);
        -> sweep_end;
        @(check_done);
        fresh_frame = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Monitor and compare
    // ----------------------------------------------------------------------
    always @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            en_cnt = 0;                     // Scan restarts at (0,0).
        end else begin
            if (diff) diff_total++;
            if (enable) en_cnt++;
            if (frame_done) begin
                gap    = en_cnt;
                en_cnt = 0;
            end
        end
    end

    initial begin : compare_proc
        snake_pkg::obj_code_t shown [CELLS];
        snake_pkg::obj_code_t exp_code;
        int changed;
        int snakes;
        int diff_seen;
        int idx;
        rd_x      = '0;
        rd_y      = '0;
        diff_seen = 0;
        forever begin
            @(sweep_end);
            if (fresh_frame) begin
                foreach (shown[i]) shown[i] = snake_pkg::blank;
            end
            changed = 0;
            snakes  = 0;
            for (int cy = 0; cy < `GRID_H; cy++) begin
                for (int cx = 0; cx < `GRID_W; cx++) begin
                    @(posedge clk);
                    #1;
                    rd_x = `COORD_W'(cx);
                    rd_y = `COORD_W'(cy);
                    @(negedge clk);
                    idx      = cy * `GRID_W + cx;
                    exp_code = expected_code(cx, cy);
                    if (exp_code != shown[idx]) changed++;
                    check(test_name, 32'(exp_code), 32'(rd_code));
                    if ((rd_code == snake_pkg::snake_head) ||
                        (rd_code == snake_pkg::snake_body)) snakes++;
                    shown[idx] = exp_code;
                end
            end
            sweep_diffs = diff_total - diff_seen;
            diff_seen   = diff_total;
            check({test_name, " diff count"}, changed, sweep_diffs);
            snake_cells = snakes;
            -> check_done;
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        snake_pkg::dir_t     d;
        logic                g;
        nrst        = 1'b0;
        enable      = 1'b0;
        step        = 1'b0;
        grow        = 1'b0;
        dir         = snake_pkg::dir_right;
        apple_load  = 1'b0;
        apple_clear = 1'b0;
        apple_x     = '0;
        apple_y     = '0;
        reset_dut();

        run_sweep("reset sweep");
        check("reset sweep diffs", 55, sweep_diffs);   // 52 border, 3 snake.
        run_sweep("idle sweep");
        check("idle sweep diffs", 0, sweep_diffs);

        for (int n = 0; n < 40; n++) begin
            d = snake_pkg::dir_t'(2'(rand_bits(2)));
            g = (rand_bits(1) != 0);
            apply_step(d, g);
            run_sweep("random step");
        end

        for (int n = 0; n < 8; n++) begin
            if (n == 7) begin
                clear_apple();
            end else if (n == 0) begin
                load_apple(m_x[0], m_y[0]);         // Hidden under the head.
            end else begin
                load_apple(1 + rand_bits(4) % (`GRID_W - 2), 1 + rand_bits(4) % (`GRID_H - 2));
            end
            run_sweep("apple");
        end

        // Park the scan on the last cell of a blank frame, then idle.
        reset_dut();
        test_name = "enable low";
        @(posedge clk);
        #1 enable = 1'b1;
        repeat (CELLS - 1) @(posedge clk);
        #1 enable = 1'b0;
        repeat (50) begin
            @(negedge clk);
            check("enable low x", `GRID_W - 1, 32'(x));
            check("enable low y", `GRID_H - 1, 32'(y));
            check("enable low diff", 0, 32'(diff));
            check("enable low frame_done", 0, 32'(frame_done));
        end
        run_sweep("enable low");

        // Right, down, then left, a path that never crosses itself.
        for (int n = 0; n < 20; n++) begin
            d = (n < 7) ? snake_pkg::dir_right :
                (n < 12) ? snake_pkg::dir_down : snake_pkg::dir_left;
            apply_step(d, 1'b1);
        end
        run_sweep("grow cap");
        check("grow cap snake cells", MAX_LEN, snake_cells);

        if (err_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "checks failed");
        end
    end

endmodule
